/* verilog/ca_pkg.sv */
`default_nettype none

package ca_pkg;

   // Sample position within one C/A code period.
   // Counts 0..16367 at 16 samples per chip.
   typedef logic [13:0] code_shift_t;

   // Chip position within one C/A code period, 0..1022.
   typedef logic [9:0] chip_idx_t;

   // Satellite number, 0-based, so 0 selects PRN 1.
   typedef logic [4:0] prn_t;

   // Chip oscillator phase accumulator.
   typedef logic [27:0] nco_acc_t;

   // Samples in one code period at 16.368 MHz.
   localparam logic [31:0] CODE_SHIFTS_PER_PERIOD = 32'd16368;

   // Chips in one C/A code period.
   localparam logic [31:0] CHIPS_PER_PERIOD = 32'd1023;

   // Phase step per sample.
   // 2^24 into a 28-bit accumulator wraps every 16 samples.
   // The MSB is high for 8 samples and low for 8.
   localparam logic [27:0] CHIP_RATE_INC = 28'h100_0000;

endpackage

`default_nettype wire

/* verilog/ca_upsampler.sv */
`default_nettype none

module ca_upsampler #(
   parameter int ACC_WIDTH = $bits(ca_pkg::nco_acc_t)
) (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire                      seek_en,
   input  wire ca_pkg::code_shift_t seek_target,
   output ca_pkg::code_shift_t      code_shift,
   output logic                     seeking,
   output logic                     chip_strobe,
   output logic                     code_wrap
);

   import ca_pkg::*;

   // Last code shift value before the counter wraps to 0.
   localparam code_shift_t LAST_SHIFT = code_shift_t'(CODE_SHIFTS_PER_PERIOD - 32'd1);

   // Oscillator step sized to the accumulator.
   // The 16-sample chip grid holds for the 28-bit package width.
   localparam logic [ACC_WIDTH-1:0] RATE_INC = ACC_WIDTH'(CHIP_RATE_INC);

   // Counter value after one more advance.
   code_shift_t next_code_shift;

   // Advance request, undelayed.
   logic adv_request;

   // Advance request piped by one cycle.
   // This is what actually moves the counter and the oscillator.
   logic advance;

   // Seek terminators.
   logic target_upcoming;
   logic target_reached;

   // Chip oscillator.
   logic [ACC_WIDTH-1:0] acc;
   logic                 acc_msb_q;

   // Counter wraps from the last value straight to 0.
   always_comb begin
      if (code_shift == LAST_SHIFT) begin
         next_code_shift = '0;
      end else begin
         next_code_shift = code_shift + code_shift_t'(1);
      end
   end

   // The target is reached once the counter sits on it.
   assign target_reached = (code_shift == seek_target);

   // An advance already in flight will land on the target.
   // Seeking must stop now or the target is overrun.
   assign target_upcoming = advance && (next_code_shift == seek_target);

   // Seek runs at one step per clock until either terminator fires.
   assign seeking = seek_en && !(target_upcoming || target_reached);

   // Advance on an input sample or while seeking.
   assign adv_request = enable || seeking;

   // One cycle of delay on the advance enable.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         advance <= 1'b0;
      end else begin
         advance <= adv_request;
      end
   end

   // Code shift counter, modulo one code period.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         code_shift <= '0;
      end else if (advance) begin
         code_shift <= next_code_shift;
      end
   end

   // Level while the counter is on its last value.
   assign code_wrap = (code_shift == LAST_SHIFT);

   // Chip oscillator.
   // Clearing it at the code wrap keeps the chip grid aligned to the period.
   // The clear wins over an advance in the same cycle.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc <= '0;
      end else if (code_wrap) begin
         acc <= '0;
      end else if (advance) begin
         acc <= acc + RATE_INC;
      end
   end

   // Previous oscillator MSB for edge detection.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc_msb_q <= 1'b0;
      end else begin
         acc_msb_q <= acc[ACC_WIDTH-1];
      end
   end

   // One-cycle strobe after the MSB falls.
   // The MSB falls once per 16 advances or at the wrap clear.
   assign chip_strobe = acc_msb_q && !acc[ACC_WIDTH-1];

endmodule

`default_nettype wire

/* verilog/gold_lfsr.sv */
`default_nettype none

module gold_lfsr #(
   parameter logic [9:0] TAPS = 10'h204
) (
   input  wire        clk,
   input  wire        arst_n,
   input  wire        step,
   input  wire        restart,
   output logic [9:0] state
);

   // Feedback bit.
   logic feedback;

   // Bit i of state is stage i+1, so state[9] is stage 10.
   // TAPS uses the same numbering.
   assign feedback = ^(state & TAPS);

   // Fibonacci register.
   // New bit enters stage 1 and the rest move toward stage 10.
   // Restart wins over step and reloads the all-ones seed.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= '1;
      end else if (restart) begin
         state <= '1;
      end else if (step) begin
         state <= {state[8:0], feedback};
      end
   end

endmodule

`default_nettype wire

/* verilog/ca_code_combiner.sv */
`default_nettype none

module ca_code_combiner (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               chip_strobe,
   input  wire               code_wrap,
   input  wire ca_pkg::prn_t prn,
   input  wire [9:0]         g1_state,
   input  wire [9:0]         g2_state,
   output logic              step,
   output logic              restart,
   output logic              out,
   output ca_pkg::chip_idx_t ca_code_shift
);

   import ca_pkg::*;

   // Index of the last chip in a period.
   localparam chip_idx_t LAST_CHIP = chip_idx_t'(CHIPS_PER_PERIOD - 32'd1);

   // G2 stage pair for the selected PRN.
   // Upper nibble is the first stage and lower nibble the second, 1-based.
   logic [7:0] g2_taps;
   logic [3:0] tap_a;
   logic [3:0] tap_b;

   // Chip formed from the current register states.
   logic chip_bit;

   // Chip index the registers currently hold.
   chip_idx_t chip_idx;

   // Code wrap seen in the previous cycle.
   logic wrap_q;

   // Standard G2 phase selector table for PRN 1..32.
   always_comb begin
      case (prn)
         5'd0:  g2_taps = {4'd2, 4'd6};
         5'd1:  g2_taps = {4'd3, 4'd7};
         5'd2:  g2_taps = {4'd4, 4'd8};
         5'd3:  g2_taps = {4'd5, 4'd9};
         5'd4:  g2_taps = {4'd1, 4'd9};
         5'd5:  g2_taps = {4'd2, 4'd10};
         5'd6:  g2_taps = {4'd1, 4'd8};
         5'd7:  g2_taps = {4'd2, 4'd9};
         5'd8:  g2_taps = {4'd3, 4'd10};
         5'd9:  g2_taps = {4'd2, 4'd3};
         5'd10: g2_taps = {4'd3, 4'd4};
         5'd11: g2_taps = {4'd5, 4'd6};
         5'd12: g2_taps = {4'd6, 4'd7};
         5'd13: g2_taps = {4'd7, 4'd8};
         5'd14: g2_taps = {4'd8, 4'd9};
         5'd15: g2_taps = {4'd9, 4'd10};
         5'd16: g2_taps = {4'd1, 4'd4};
         5'd17: g2_taps = {4'd2, 4'd5};
         5'd18: g2_taps = {4'd3, 4'd6};
         5'd19: g2_taps = {4'd4, 4'd7};
         5'd20: g2_taps = {4'd5, 4'd8};
         5'd21: g2_taps = {4'd6, 4'd9};
         5'd22: g2_taps = {4'd1, 4'd3};
         5'd23: g2_taps = {4'd4, 4'd6};
         5'd24: g2_taps = {4'd5, 4'd7};
         5'd25: g2_taps = {4'd6, 4'd8};
         5'd26: g2_taps = {4'd7, 4'd9};
         5'd27: g2_taps = {4'd8, 4'd10};
         5'd28: g2_taps = {4'd1, 4'd6};
         5'd29: g2_taps = {4'd2, 4'd7};
         5'd30: g2_taps = {4'd3, 4'd8};
         5'd31: g2_taps = {4'd4, 4'd9};
      endcase
   end

   assign tap_a = g2_taps[7:4];
   assign tap_b = g2_taps[3:0];

   // Stage n sits at bit n-1 of the register state.
   assign chip_bit = g1_state[9] ^ g2_state[tap_a - 4'd1] ^ g2_state[tap_b - 4'd1];

   // Both registers advance once per chip.
   assign step = chip_strobe;

   // The wrap strobe comes the cycle after the oscillator clear.
   // Hence the delayed wrap flag.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wrap_q <= 1'b0;
      end else begin
         wrap_q <= code_wrap;
      end
   end

   // Reseed after the last chip of a period or at the code wrap strobe.
   assign restart = chip_strobe && ((chip_idx == LAST_CHIP) || wrap_q);

   // Chip counter follows the register contents.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         chip_idx <= '0;
      end else if (restart) begin
         chip_idx <= '0;
      end else if (chip_strobe) begin
         chip_idx <= chip_idx + chip_idx_t'(1);
      end
   end

   // Output chip and its index, taken before the registers step.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out           <= 1'b0;
         ca_code_shift <= '0;
      end else if (chip_strobe) begin
         out           <= chip_bit;
         ca_code_shift <= chip_idx;
      end
   end

endmodule

`default_nettype wire

/* verilog/ca_channel_top.sv */
`default_nettype none

module ca_channel_top #(
   // G1 feedback from stages 3 and 10.
   parameter logic [9:0] G1_TAPS = 10'h204,
   // G2 feedback from stages 2, 3, 6, 8, 9 and 10.
   parameter logic [9:0] G2_TAPS = 10'h3A6
) (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire ca_pkg::prn_t        prn,
   input  wire                      seek_en,
   input  wire ca_pkg::code_shift_t seek_target,
   output ca_pkg::code_shift_t      code_shift,
   output logic                     out,
   output logic                     seeking,
   output logic                     ca_clk,
   output ca_pkg::chip_idx_t        ca_code_shift
);

   import ca_pkg::*;

   // Oscillator to combiner.
   logic code_wrap;

   // Combiner controls to both Gold registers.
   logic step;
   logic restart;

   // Register states back to the combiner.
   logic [9:0] g1_state;
   logic [9:0] g2_state;

   // Code shift counter, seek and chip oscillator.
   ca_upsampler #(
      .ACC_WIDTH($bits(nco_acc_t))
   ) u_upsampler (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .seek_en    (seek_en),
      .seek_target(seek_target),
      .code_shift (code_shift),
      .seeking    (seeking),
      .chip_strobe(ca_clk),
      .code_wrap  (code_wrap)
   );

   // G1 register.
   gold_lfsr #(
      .TAPS(G1_TAPS)
   ) g1 (
      .clk    (clk),
      .arst_n (arst_n),
      .step   (step),
      .restart(restart),
      .state  (g1_state)
   );

   // G2 register.
   gold_lfsr #(
      .TAPS(G2_TAPS)
   ) g2 (
      .clk    (clk),
      .arst_n (arst_n),
      .step   (step),
      .restart(restart),
      .state  (g2_state)
   );

   // PRN selection and output chip.
   ca_code_combiner u_combiner (
      .clk          (clk),
      .arst_n       (arst_n),
      .chip_strobe  (ca_clk),
      .code_wrap    (code_wrap),
      .prn          (prn),
      .g1_state     (g1_state),
      .g2_state     (g2_state),
      .step         (step),
      .restart      (restart),
      .out          (out),
      .ca_code_shift(ca_code_shift)
   );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running 10 ns clock.
   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Reset held for a number of cycles, released away from the rising edge.
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb/ca_channel_assert.sv */
`default_nettype none

module ca_channel_assert (
   input wire                      clk,
   input wire                      arst_n,
   input wire                      enable,
   input wire                      seek_en,
   input wire ca_pkg::code_shift_t seek_target,
   input wire ca_pkg::code_shift_t code_shift,
   input wire                      seeking,
   input wire                      ca_clk,
   input wire                      out
);

   timeunit 1ns;
   timeprecision 100ps;

   import ca_pkg::*;

   // Last code shift of a period.
   localparam code_shift_t LAST_SHIFT = code_shift_t'(CODE_SHIFTS_PER_PERIOD - 32'd1);

   // Failed assertions so far.
   int unsigned fail_count = 0;

   // Code shift after one more advance, modulo one period.
   function automatic code_shift_t shift_plus_one(input code_shift_t v);
      if (v == LAST_SHIFT) begin
         return '0;
      end
      return v + code_shift_t'(1);
   endfunction

   function automatic void flag_failure(input string what);
      $error("Assertion failed: %s", what);
      fail_count++;
   endfunction

   // Idle outputs right after reset.
   reset_state: assert property (@(posedge clk)
      $rose(arst_n) |-> (!seeking && !ca_clk && !out && code_shift == '0))
      else flag_failure("outputs not idle after reset");

   // An advance request moves the counter two edges later.
   advance_step: assert property (@(posedge clk) disable iff (!arst_n)
      (enable || seeking) |-> ##2 (code_shift == shift_plus_one($past(code_shift))))
      else flag_failure("code shift did not advance by one");

   // No request, no movement.
   advance_hold: assert property (@(posedge clk) disable iff (!arst_n)
      !(enable || seeking) |-> ##2 (code_shift == $past(code_shift)))
      else flag_failure("code shift moved without an advance");

   // Every step onto a nonzero multiple of 16 gives a strobe.
   strobe_on_grid: assert property (@(posedge clk) disable iff (!arst_n)
      ($changed(code_shift) && code_shift[3:0] == 4'd0 && code_shift != '0) |-> ca_clk)
      else flag_failure("chip strobe missing after 16 advances");

   // Strobes only in the first cycle on a grid point.
   // At the wrap, only in the cycle after the counter reached its last value.
   strobe_only_on_grid: assert property (@(posedge clk) disable iff (!arst_n)
      ca_clk |-> (($changed(code_shift) && code_shift[3:0] == 4'd0) ||
                  ($past(code_shift) == LAST_SHIFT && $past(code_shift, 2) != LAST_SHIFT)))
      else flag_failure("chip strobe off the 16-sample grid");

   // When seeking drops, the counter lands on the target next cycle.
   seek_lands: assert property (@(posedge clk) disable iff (!arst_n)
      ($fell(seeking) && seek_en && !enable) |=> (code_shift == seek_target))
      else flag_failure("seek did not settle on its target");

   // Settled seek stays put with enable low.
   seek_holds: assert property (@(posedge clk) disable iff (!arst_n)
      (seek_en && !enable && code_shift == seek_target) [*2] |=> (code_shift == seek_target))
      else flag_failure("code shift left the seek target");

endmodule

bind ca_channel_top ca_channel_assert u_assert (.*);

`default_nettype wire

/* tb/ca_channel_tb.sv */
`default_nettype none

module ca_channel_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import ca_pkg::*;

   // Chips before the wrap in the wrap run.
   localparam int WRAP_LEAD  = 40;
   localparam int SEEK_LIMIT = 17000;

   // PRN 1, 7 and 20, 0-based.
   localparam prn_t PRN_LIST [3] = '{5'd0, 5'd6, 5'd19};

   // G2 stage pairs for PRN 1..32.
   localparam int TAP_A [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                                 1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
   localparam int TAP_B [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                                 4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};

   logic        clk;
   logic        arst_n;
   logic        enable;
   prn_t        prn;
   logic        seek_en;
   code_shift_t seek_target;
   code_shift_t code_shift;
   logic        out;
   logic        seeking;
   logic        ca_clk;
   chip_idx_t   ca_code_shift;

   // Reference Gold registers, stage 1 on the left.
   logic [1:10] g1_ref;
   logic [1:10] g2_ref;
   logic        fb1;
   logic        fb2;
   int unsigned ref_idx;

   // Chip expected on the edge after a strobe.
   logic        exp_out;
   int unsigned exp_idx;
   logic        check_pending;

   int unsigned chips_seen  = 0;
   int unsigned chip_errors = 0;
   int unsigned seek_errors = 0;
   int unsigned timeouts    = 0;
   logic [31:0] lfsr        = 32'h286c;

   tb_clock_gen u_clock (
      .clk   (clk),
      .arst_n(arst_n)
   );

   ca_channel_top DUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .prn          (prn),
      .seek_en      (seek_en),
      .seek_target  (seek_target),
      .code_shift   (code_shift),
      .out          (out),
      .seeking      (seeking),
      .ca_clk       (ca_clk),
      .ca_code_shift(ca_code_shift)
   );

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit.
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // Chip model and compare, sampled mid-cycle.
   always @(negedge clk) begin
      if (!arst_n) begin
         g1_ref = '1;
         g2_ref = '1;
         ref_idx = 0;
         check_pending = 1'b0;
      end else begin
         if (check_pending && (out !== exp_out || ca_code_shift !== chip_idx_t'(exp_idx))) begin
            $display("ERR %0t: chip out %b idx %0d, expected out %b idx %0d",
                     $time, out, ca_code_shift, exp_out, exp_idx);
            chip_errors++;
         end
         check_pending = ca_clk;
         if (ca_clk) begin
            exp_out = g1_ref[10] ^ g2_ref[TAP_A[prn]] ^ g2_ref[TAP_B[prn]];
            exp_idx = ref_idx;
            chips_seen++;
            fb1 = g1_ref[3] ^ g1_ref[10];
            fb2 = g2_ref[2] ^ g2_ref[3] ^ g2_ref[6] ^ g2_ref[8] ^ g2_ref[9] ^ g2_ref[10];
            // Both registers reseed after the last chip of a period.
            if (ref_idx == CHIPS_PER_PERIOD - 1) begin
               g1_ref = '1;
               g2_ref = '1;
               ref_idx = 0;
            end else begin
               g1_ref = {fb1, g1_ref[1:9]};
               g2_ref = {fb2, g2_ref[1:9]};
               ref_idx++;
            end
         end
      end
   end

   task automatic wait_for_reset();
      int unsigned cycles;
      cycles = 0;
      while (!arst_n && cycles < 50) begin
         @(posedge clk);
         cycles++;
      end
      if (!arst_n) begin
         $display("Timeout: reset was never released");
         timeouts++;
      end
   endtask

   // Random enable gaps until n more chips have come out.
   task automatic run_chips(input int n);
      int unsigned goal;
      int unsigned cycles;
      logic [31:0] bits;
      goal = chips_seen + n;
      cycles = 0;
      while (chips_seen < goal && cycles < n * 128 + 64) begin
         @(posedge clk);
         #1;
         take_bits(2, bits);
         enable = |bits[1:0];
         cycles++;
      end
      @(posedge clk);
      #1;
      enable = 1'b0;
      if (chips_seen < goal) begin
         $display("Timeout: only %0d of %0d chips came out", n - (goal - chips_seen), n);
         timeouts++;
      end
   endtask

   task automatic seek_to(input code_shift_t target);
      int unsigned cycles;
      // Idle long enough that no advance is still pending.
      @(posedge clk);
      #1;
      enable = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      seek_target = target;
      seek_en = 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!(code_shift == target && !seeking) && cycles < SEEK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= SEEK_LIMIT) begin
         $display("Timeout: seek to %0d did not settle in %0d cycles", target, SEEK_LIMIT);
         timeouts++;
      end else begin
         repeat (3) @(negedge clk);
         if (code_shift !== target) begin
            $display("ERR %0t: code shift %0d after seek, expected %0d", $time, code_shift, target);
            seek_errors++;
         end
      end
      @(posedge clk);
      #1;
      seek_en = 1'b0;
   endtask

   initial begin
      logic [31:0] bits;
      int unsigned asserts_failed;
      enable = 1'b0;
      prn = '0;
      seek_en = 1'b0;
      seek_target = '0;
      wait_for_reset();
      foreach (PRN_LIST[i]) begin
         @(posedge clk);
         #1;
         prn = PRN_LIST[i];
         // Period start; crosses the wrap after the first pass.
         seek_to('0);
         run_chips(64);
         // Random target, forward or across the wrap.
         take_bits(14, bits);
         seek_to(code_shift_t'(bits % CODE_SHIFTS_PER_PERIOD));
         run_chips(8);
         // Just short of the wrap, then run through it.
         seek_to(code_shift_t'(CODE_SHIFTS_PER_PERIOD - 16 * WRAP_LEAD));
         run_chips(2 * WRAP_LEAD);
      end
      repeat (4) @(posedge clk);
      asserts_failed = DUT.u_assert.fail_count;
      $display("Errors: chip %0d, seek %0d, timeout %0d, assertion %0d over %0d chips",
               chip_errors, seek_errors, timeouts, asserts_failed, chips_seen);
      if (chip_errors + seek_errors + timeouts + asserts_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
verilog/ca_pkg.sv
verilog/ca_upsampler.sv
verilog/gold_lfsr.sv
verilog/ca_code_combiner.sv
verilog/ca_channel_top.sv
tb/tb_clock_gen.sv
tb/ca_channel_assert.sv
tb/ca_channel_tb.sv
